//--- bench/tb_dp_model.svh
// Reference model: lane swap, PHY word packing and unpacking, PIO status, heartbeat toggles
`ifndef TB_DP_MODEL_SVH
`define TB_DP_MODEL_SVH

// Board swap, transmit side
function automatic int tx_chan(input int lane);
    case (lane)
        0:       return 1;
        1:       return 0;
        default: return lane;
    endcase
endfunction

// Board swap, receive side
function automatic int rx_chan(input int lane);
    case (lane)
        0:       return 3;
        1:       return 2;
        2:       return 0;
        default: return 1;
    endcase
endfunction

// Symbol s at bit 10*s, disparity values from bit 44, controls from bit 40
function automatic phy_bus_t pack_tx(input tx_lnk_t lnk);
    phy_bus_t bus;
    tx_sym_t  sym;
    int       ch;
    bus = '0;
    for (int lane = 0; lane < 4; lane++)
    begin
        ch = tx_chan(lane);
        for (int s = 0; s < 4; s++)
        begin
            sym = lnk[lane*4 + s];
            bus[ch][10*s +: 9] = {sym.k, sym.dat};
            bus[ch][44 + s]    = sym.disp_val;
            bus[ch][40 + s]    = sym.disp_ctl;
        end
    end
    return bus;
endfunction

function automatic rx_lnk_t unpack_rx(input phy_bus_t bus);
    rx_lnk_t lnk;
    for (int lane = 0; lane < 4; lane++)
    begin
        for (int s = 0; s < 4; s++)
            lnk[lane*4 + s] = bus[rx_chan(lane)][10*s +: 9];    // Pad and disparity dropped
    end
    return lnk;
endfunction

// PHY ready only when all four channels are
function automatic logic [5:0] status_of(input logic pll, input logic vll, input logic [3:0] rdy);
    return {3'b000, &rdy, vll, pll};
endfunction

function automatic int beat_toggles(input int events, input int beat);
    return events / beat;
endfunction

`endif

//--- bench/tb_dp_phy_adapter.sv
// Testbench for the PHY adapter: clock, reset, random stimulus, compare tasks, test sequence
`timescale 1ns/100ps

module tb_dp_phy_adapter
    import dp_sys_pkg::*;
    import dp_link_pkg::*;
();

    `include "tb_dp_model.svh"

    localparam int STRETCH = 2**RST_CNT_W - 1;     // Cycles of lock before release
    localparam int HB_WIN  = 20 * 16;

    logic       sys_clk;
    logic       rst_i;
    logic       pll_lock_i;
    logic       pio_wr_i;
    logic [7:0] pio_dat_i;
    logic       phy_clk_lock_i;
    logic       vid_clk_lock_i;
    logic [3:0] phy_rdy_i;
    logic [5:0] pio_dat_o;
    logic       clk_sel_o;
    logic       dptx_rst_o;
    logic       dprx_rst_o;
    tx_lnk_t    lnk_tx_dat_i;
    logic       lnk_tx_vld_i;
    phy_bus_t   phy_tx_dat_o;
    logic       phy_tx_vld_o;
    phy_bus_t   phy_rx_dat_i;
    logic       phy_rx_vld_i;
    rx_lnk_t    lnk_rx_dat_o;
    logic       lnk_rx_vld_o;
    logic [7:0] led_o;

    int         checks;
    int         errors;
    int         tests;
    bit         timed_out;
    int         tx_events;              // Words the model expects on each side
    int         rx_events;
    int         tog [3];
    logic [2:0] led_prev;

    dp_phy_adapter_top #(.P_SYS_BEAT (16), .P_LNK_BEAT (8)) DUT
    (
        .sys_clk_i      (sys_clk),
        .rst_i          (rst_i),
        .pll_lock_i     (pll_lock_i),
        .pio_wr_i       (pio_wr_i),
        .pio_dat_i      (pio_dat_i),
        .phy_clk_lock_i (phy_clk_lock_i),
        .vid_clk_lock_i (vid_clk_lock_i),
        .phy_rdy_i      (phy_rdy_i),
        .pio_dat_o      (pio_dat_o),
        .clk_sel_o      (clk_sel_o),
        .dptx_rst_o     (dptx_rst_o),
        .dprx_rst_o     (dprx_rst_o),
        .lnk_tx_dat_i   (lnk_tx_dat_i),
        .lnk_tx_vld_i   (lnk_tx_vld_i),
        .phy_tx_dat_o   (phy_tx_dat_o),
        .phy_tx_vld_o   (phy_tx_vld_o),
        .phy_rx_dat_i   (phy_rx_dat_i),
        .phy_rx_vld_i   (phy_rx_vld_i),
        .lnk_rx_dat_o   (lnk_rx_dat_o),
        .lnk_rx_vld_o   (lnk_rx_vld_o),
        .led_o          (led_o)
    );

    always #2 sys_clk = ~sys_clk;

    // LED toggle counter, sampled away from the active edge
    always @(negedge sys_clk)
    begin
        for (int k = 0; k < 3; k++)
        begin
            if (led_o[k] !== led_prev[k])
                tog[k]++;
        end
        led_prev = led_o[2:0];
    end

    task automatic check_phy_bus(input phy_bus_t got, input phy_bus_t exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_rx_lnk(input rx_lnk_t got, input rx_lnk_t exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bits(input logic [7:0] got, input logic [7:0] exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int lo, input int hi, input string what);
        checks++;
        if (got < lo || got > hi)
        begin
            errors++;
            $display("** Error at %0t ns: %s is %0d, expected %0d to %0d",
                     $time, what, got, lo, hi);
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        tests++;
        $display("Test %0d %s finished with %0d errors", tests, name, errors - err_start);
    endtask

    function automatic tx_lnk_t rand_tx_lnk();
        tx_lnk_t w;
        for (int i = 0; i < P_SYMS; i++)
            w[i] = 11'($urandom);
        return w;
    endfunction

    // Pad and disparity bits random as well
    function automatic phy_bus_t rand_phy_bus();
        phy_bus_t b;
        for (int c = 0; c < P_LANES; c++)
            b[c] = 80'({$urandom, $urandom, $urandom});
        return b;
    endfunction

    task automatic pio_write(input logic [7:0] val);
        @(posedge sys_clk);
        pio_wr_i  <= 1'b1;
        pio_dat_i <= val;
        @(posedge sys_clk);
        pio_wr_i  <= 1'b0;
    endtask

    // Writes clk_sel every cycle, which only lands once the stretch is over
    task automatic wait_release();
        int cycles;
        cycles = 0;
        while (!timed_out)
        begin
            @(posedge sys_clk);
            pio_wr_i  <= 1'b1;
            pio_dat_i <= 8'h01;
            @(negedge sys_clk);
            cycles++;
            if (clk_sel_o === 1'b1)
                break;
            check_bits({dprx_rst_o, dptx_rst_o, clk_sel_o}, PIO_RST_VAL[2:0], "held PIO bits");
            if (cycles > STRETCH + 8)
            begin
                $display("Timeout: the system reset was not released after lock");
                timed_out = 1'b1;
            end
        end
        @(posedge sys_clk);
        pio_wr_i <= 1'b0;
        // Stretch plus one cycle for the control register
        if (!timed_out)
            check_count(cycles, STRETCH + 1, STRETCH + 1, "cycles to release");
    endtask

    task automatic pio_test(input int n);
        logic [7:0] model;
        logic       wr;
        logic [7:0] wr_dat;
        logic [5:0] sts_exp;
        logic       nw;
        logic [7:0] nd;
        logic       npl;
        logic       nvl;
        logic [3:0] nrdy;
        model   = 8'h01;                    // Left by the release wait
        wr      = 1'b0;
        wr_dat  = '0;
        sts_exp = status_of(phy_clk_lock_i, vid_clk_lock_i, phy_rdy_i);
        for (int i = 0; i <= n; i++)
        begin
            nw   = (i < n) && ($urandom_range(1) == 1);
            nd   = 8'($urandom);
            npl  = 1'($urandom);
            nvl  = 1'($urandom);
            nrdy = $urandom_range(1) ? 4'hF : 4'($urandom);
            @(posedge sys_clk);
            pio_wr_i       <= nw;
            pio_dat_i      <= nd;
            phy_clk_lock_i <= npl;
            vid_clk_lock_i <= nvl;
            phy_rdy_i      <= nrdy;
            @(negedge sys_clk);
            if (wr)
                model = wr_dat;
            check_bits({dprx_rst_o, dptx_rst_o, clk_sel_o},
                       {model[PIO_DPRX_RST], model[PIO_DPTX_RST], model[PIO_CLK_SEL]},
                       "PIO control bits");
            check_bits(pio_dat_o, sts_exp, "PIO status");
            wr      = nw;
            wr_dat  = nd;
            sts_exp = status_of(npl, nvl, nrdy);
        end
    endtask

    // Output in one cycle must be the packing of the word driven the cycle before
    task automatic run_tx(input int n, input bit dense, input bit hold);
        tx_lnk_t prev_dat;
        tx_lnk_t nxt_dat;
        bit      prev_vld;
        bit      nxt_vld;
        prev_vld = 1'b0;
        prev_dat = '0;
        for (int i = 0; i <= n; i++)
        begin
            nxt_vld = (i < n) && (dense || $urandom_range(2) != 0);
            nxt_dat = rand_tx_lnk();
            @(posedge sys_clk);
            lnk_tx_vld_i <= nxt_vld;
            lnk_tx_dat_i <= nxt_dat;
            @(negedge sys_clk);
            if (hold)
            begin
                check_bits(phy_tx_vld_o, 1'b0, "tx valid in hold");
                check_phy_bus(phy_tx_dat_o, '0, "tx data in hold");
            end
            else
            begin
                check_bits(phy_tx_vld_o, prev_vld, "tx valid");
                if (prev_vld)
                begin
                    check_phy_bus(phy_tx_dat_o, pack_tx(prev_dat), "tx word");
                    tx_events++;
                end
            end
            prev_vld = nxt_vld;
            prev_dat = nxt_dat;
        end
    endtask

    task automatic run_rx(input int n, input bit hold);
        phy_bus_t prev_dat;
        phy_bus_t nxt_dat;
        bit       prev_vld;
        bit       nxt_vld;
        prev_vld = 1'b0;
        prev_dat = '0;
        for (int i = 0; i <= n; i++)
        begin
            nxt_vld = (i < n) && ($urandom_range(3) != 0);
            nxt_dat = rand_phy_bus();
            @(posedge sys_clk);
            phy_rx_vld_i <= nxt_vld;
            phy_rx_dat_i <= nxt_dat;
            @(negedge sys_clk);
            if (hold)
            begin
                check_bits(lnk_rx_vld_o, 1'b0, "rx valid in hold");
                check_rx_lnk(lnk_rx_dat_o, '0, "rx data in hold");
            end
            else
            begin
                check_bits(lnk_rx_vld_o, prev_vld, "rx valid");
                if (prev_vld)
                begin
                    check_rx_lnk(lnk_rx_dat_o, unpack_rx(prev_dat), "rx word");
                    rx_events++;
                end
            end
            prev_vld = nxt_vld;
            prev_dat = nxt_dat;
        end
    endtask

    task automatic beat_test();
        int t0;
        repeat (4) @(posedge sys_clk);
        t0 = tog[0];
        repeat (HB_WIN) @(posedge sys_clk);
        check_count(tog[0] - t0, beat_toggles(HB_WIN, 16), beat_toggles(HB_WIN, 16),
                    "LED 0 toggles");
        check_count(tog[1], beat_toggles(tx_events, 8), beat_toggles(tx_events, 8),
                    "LED 1 toggles");
        check_count(tog[2], beat_toggles(rx_events, 8), beat_toggles(rx_events, 8),
                    "LED 2 toggles");
        @(negedge sys_clk);
        check_bits(led_o[7:3], 5'b0_0000, "unused LEDs");
    endtask

    task automatic run_tests();
        int e0;
        e0 = errors;
        wait_release();
        if (timed_out)
            return;
        @(posedge sys_clk);
        pll_lock_i <= 1'b0;
        pio_wr_i   <= 1'b1;
        pio_dat_i  <= 8'h01;
        @(posedge sys_clk);
        pio_wr_i   <= 1'b0;
        repeat (3) @(posedge sys_clk);
        @(negedge sys_clk);
        check_bits({dprx_rst_o, dptx_rst_o, clk_sel_o}, PIO_RST_VAL[2:0], "PIO bits, lock lost");
        @(posedge sys_clk);
        pll_lock_i <= 1'b1;
        wait_release();
        if (timed_out)
            return;
        tx_events = 0;                      // Heartbeats restart with this release
        rx_events = 0;
        tog       = '{0, 0, 0};
        report_test("reset and lock", e0);

        e0 = errors;
        pio_test(200);
        report_test("PIO write and status", e0);

        e0 = errors;
        pio_write(8'h00);
        run_tx(64, 1'b1, 1'b0);             // Back to back
        run_tx(128, 1'b0, 1'b0);
        report_test("transmit mapping", e0);

        e0 = errors;
        pio_write(8'd1 << PIO_PHY_TX_RST);
        run_tx(32, 1'b0, 1'b1);
        pio_write(8'd1 << PIO_PHY_ALL_RST);
        run_tx(32, 1'b1, 1'b1);
        pio_write(8'h00);
        run_tx(16, 1'b1, 1'b0);
        report_test("transmit hold", e0);

        e0 = errors;
        run_rx(160, 1'b0);
        pio_write(8'd1 << PIO_PHY_RX_RST);
        run_rx(32, 1'b1);
        pio_write(8'h00);
        run_rx(16, 1'b0);
        report_test("receive mapping", e0);

        e0 = errors;
        beat_test();
        report_test("heartbeats", e0);
    endtask

    initial
    begin
        void'($urandom(32'h83d));
        sys_clk        = 1'b0;
        rst_i          = 1'b1;
        pll_lock_i     = 1'b1;
        pio_wr_i       = 1'b0;
        pio_dat_i      = '0;
        phy_clk_lock_i = 1'b0;
        vid_clk_lock_i = 1'b0;
        phy_rdy_i      = '0;
        lnk_tx_dat_i   = '0;
        lnk_tx_vld_i   = 1'b0;
        phy_rx_dat_i   = '0;
        phy_rx_vld_i   = 1'b0;
        led_prev       = '0;
        tog            = '{0, 0, 0};
        repeat (16) @(posedge sys_clk);
        rst_i <= 1'b0;
        run_tests();
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && !timed_out)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

//--- rtl/dp_heartbeat.sv
// Heartbeat toggle counter advancing on an enable
`timescale 1ns/100ps

module dp_heartbeat
#(
    parameter int P_BEAT = 25_000_000       // Enables per toggle
)
(
    input  logic sys_clk_i,
    input  logic rst_i,
    input  logic en_i,
    output logic led_o
);

    localparam int CNT_W = (P_BEAT > 1) ? $clog2(P_BEAT) : 1;

    logic [CNT_W-1:0] beat_cnt;
    logic             led;

    always_ff @(posedge sys_clk_i)
    begin
        if (rst_i)
        begin
            beat_cnt <= '0;
            led      <= 1'b0;
        end
        else if (en_i)
        begin
            if (beat_cnt == CNT_W'(P_BEAT - 1))
            begin
                beat_cnt <= '0;
                led      <= ~led;
            end
            else
                beat_cnt <= beat_cnt + 1'b1;
        end
    end

    assign led_o = led;

endmodule

//--- rtl/dp_link_pkg.sv
// Link geometry, symbol types, PHY word types and lane swap tables
package dp_link_pkg;

    localparam int P_LANES = 4;             // DP lanes
    localparam int P_SPL   = 4;             // Symbols per lane per word
    localparam int P_SYMS  = P_LANES * P_SPL;

    // PHY channel word layout
    localparam int P_PHY_W        = 80;
    localparam int P_SYM_W        = 9;      // Data plus K
    localparam int P_SYM_PITCH    = 10;     // One pad bit per slot
    localparam int P_DISP_CTL_LSB = 40;
    localparam int P_DISP_VAL_LSB = 44;

    // Transmit symbol from the DPTX core
    typedef struct packed {
        logic       disp_ctl;               // 0 automatic, 1 force
        logic       disp_val;               // 0 negative, 1 positive
        logic       k;
        logic [7:0] dat;
    } tx_sym_t;

    // Receive symbol to the DPRX core
    typedef struct packed {
        logic       k;
        logic [7:0] dat;
    } rx_sym_t;

    typedef logic [P_PHY_W-1:0] phy_word_t;

    // Lane-major, index is lane * P_SPL + symbol
    typedef tx_sym_t   [P_SYMS-1:0]  tx_lnk_t;
    typedef rx_sym_t   [P_SYMS-1:0]  rx_lnk_t;
    typedef phy_word_t [P_LANES-1:0] phy_bus_t;    // By PHY channel

    typedef logic [1:0] ch_idx_t;

    // Board lane swap, entry [lane] gives the PHY channel
    localparam ch_idx_t [P_LANES-1:0] TX_CH_OF_LANE = {2'd3, 2'd2, 2'd0, 2'd1};
    localparam ch_idx_t [P_LANES-1:0] RX_CH_OF_LANE = {2'd1, 2'd0, 2'd2, 2'd3};

endpackage

//--- rtl/dp_phy_adapter_top.sv
// Top level of the PHY adapter with reset, PIO, lane mappers and heartbeat LEDs
`timescale 1ns/100ps

module dp_phy_adapter_top
    import dp_sys_pkg::*;
    import dp_link_pkg::*;
#(
    parameter int P_SYS_BEAT = 25_000_000,  // System cycles per toggle
    parameter int P_LNK_BEAT = 67_500_000   // Link words per toggle
)
(
    input  logic                 sys_clk_i,
    input  logic                 rst_i,
    input  logic                 pll_lock_i,

    // PIO
    input  logic                 pio_wr_i,
    input  logic [PIO_OUT_W-1:0] pio_dat_i,
    input  logic                 phy_clk_lock_i,
    input  logic                 vid_clk_lock_i,
    input  logic [3:0]           phy_rdy_i,
    output logic [PIO_IN_W-1:0]  pio_dat_o,
    output logic                 clk_sel_o,
    output logic                 dptx_rst_o,
    output logic                 dprx_rst_o,

    // Transmit link
    input  tx_lnk_t              lnk_tx_dat_i,
    input  logic                 lnk_tx_vld_i,
    output phy_bus_t             phy_tx_dat_o,
    output logic                 phy_tx_vld_o,

    // Receive link
    input  phy_bus_t             phy_rx_dat_i,
    input  logic                 phy_rx_vld_i,
    output rx_lnk_t              lnk_rx_dat_o,
    output logic                 lnk_rx_vld_o,

    output logic [7:0]           led_o
);

    logic sys_rst;
    logic led_sys_hb;
    logic led_tx_hb;
    logic led_rx_hb;

    dp_rst_if rst_if ();

    dp_rst_gen u_rst_gen
    (
        .sys_clk_i  (sys_clk_i),
        .rst_i      (rst_i),
        .pll_lock_i (pll_lock_i),
        .sys_rst_o  (sys_rst)
    );

    dp_pio_regs u_pio_regs
    (
        .sys_clk_i      (sys_clk_i),
        .rst_i          (sys_rst),
        .pio_wr_i       (pio_wr_i),
        .pio_dat_i      (pio_dat_i),
        .phy_clk_lock_i (phy_clk_lock_i),
        .vid_clk_lock_i (vid_clk_lock_i),
        .phy_rdy_i      (phy_rdy_i),
        .pio_dat_o      (pio_dat_o),
        .clk_sel_o      (clk_sel_o),
        .rst_if         (rst_if)
    );

    assign dptx_rst_o = rst_if.dptx_rst;    // Core resets go off chip
    assign dprx_rst_o = rst_if.dprx_rst;

    dp_tx_lane_map u_tx_lane_map
    (
        .sys_clk_i    (sys_clk_i),
        .rst_i        (sys_rst),
        .rst_if       (rst_if),
        .lnk_tx_dat_i (lnk_tx_dat_i),
        .lnk_tx_vld_i (lnk_tx_vld_i),
        .phy_tx_dat_o (phy_tx_dat_o),
        .phy_tx_vld_o (phy_tx_vld_o)
    );

    dp_rx_lane_map u_rx_lane_map
    (
        .sys_clk_i    (sys_clk_i),
        .rst_i        (sys_rst),
        .rst_if       (rst_if),
        .phy_rx_dat_i (phy_rx_dat_i),
        .phy_rx_vld_i (phy_rx_vld_i),
        .lnk_rx_dat_o (lnk_rx_dat_o),
        .lnk_rx_vld_o (lnk_rx_vld_o)
    );

    // Counts every system cycle
    dp_heartbeat #(.P_BEAT (P_SYS_BEAT)) u_sys_hb
    (
        .sys_clk_i (sys_clk_i),
        .rst_i     (sys_rst),
        .en_i      (1'b1),
        .led_o     (led_sys_hb)
    );

    dp_heartbeat #(.P_BEAT (P_LNK_BEAT)) u_tx_hb
    (
        .sys_clk_i (sys_clk_i),
        .rst_i     (sys_rst),
        .en_i      (phy_tx_vld_o),          // Words sent to the PHY
        .led_o     (led_tx_hb)
    );

    dp_heartbeat #(.P_BEAT (P_LNK_BEAT)) u_rx_hb
    (
        .sys_clk_i (sys_clk_i),
        .rst_i     (sys_rst),
        .en_i      (lnk_rx_vld_o),          // Words handed to the link
        .led_o     (led_rx_hb)
    );

    // LEDs 3 to 7 unused
    assign led_o = {5'b0_0000, led_rx_hb, led_tx_hb, led_sys_hb};

endmodule

//--- rtl/dp_pio_regs.sv
// PIO control register and status readback for clock select and reset controls
`timescale 1ns/100ps

module dp_pio_regs
    import dp_sys_pkg::*;
(
    input  logic                 sys_clk_i,
    input  logic                 rst_i,
    input  logic                 pio_wr_i,          // Single-cycle strobe
    input  logic [PIO_OUT_W-1:0] pio_dat_i,
    input  logic                 phy_clk_lock_i,
    input  logic                 vid_clk_lock_i,
    input  logic [3:0]           phy_rdy_i,         // Per PHY channel
    output logic [PIO_IN_W-1:0]  pio_dat_o,
    output logic                 clk_sel_o,
    dp_rst_if.ctl                rst_if
);

    logic [PIO_OUT_W-1:0] pio_out;
    logic [PIO_IN_W-1:0]  sts_nxt;
    logic [PIO_IN_W-1:0]  pio_sts;

    // Control register
    always_ff @(posedge sys_clk_i)
    begin
        if (rst_i)
            pio_out <= PIO_RST_VAL;
        else if (pio_wr_i)
            pio_out <= pio_dat_i;
    end

    // Status bits
    always_comb
    begin
        sts_nxt                   = '0;
        sts_nxt[PIO_PHY_CLK_LOCK] = phy_clk_lock_i;
        sts_nxt[PIO_VID_CLK_LOCK] = vid_clk_lock_i;
        sts_nxt[PIO_PHY_RDY]      = &phy_rdy_i;      // All four channels
    end

    always_ff @(posedge sys_clk_i)
    begin
        pio_sts <= sts_nxt;
    end

    assign pio_dat_o = pio_sts;

    // Output bit decode
    assign clk_sel_o          = pio_out[PIO_CLK_SEL];
    assign rst_if.dptx_rst    = pio_out[PIO_DPTX_RST];
    assign rst_if.dprx_rst    = pio_out[PIO_DPRX_RST];
    assign rst_if.phy_all_rst = pio_out[PIO_PHY_ALL_RST];
    assign rst_if.phy_tx_rst  = pio_out[PIO_PHY_TX_RST];
    assign rst_if.phy_rx_rst  = pio_out[PIO_PHY_RX_RST];

endmodule

//--- rtl/dp_rst_gen.sv
// Reset stretcher that releases the system reset once PLL lock has been stable
`timescale 1ns/100ps

module dp_rst_gen
    import dp_sys_pkg::*;
(
    input  logic sys_clk_i,
    input  logic rst_i,
    input  logic pll_lock_i,
    output logic sys_rst_o
);

    logic [RST_CNT_W-1:0] rst_cnt;
    logic                 sys_rst;

    always_ff @(posedge sys_clk_i)
    begin
        if (rst_i || !pll_lock_i)
        begin
            rst_cnt <= '0;
            sys_rst <= 1'b1;
        end
        else
        begin
            if (rst_cnt != RST_CNT_MAX)
                rst_cnt <= rst_cnt + 1'b1;          // Saturates at the top

            // Falls on the edge the counter saturates
            sys_rst <= (rst_cnt < RST_CNT_MAX - 1'b1);
        end
    end

    assign sys_rst_o = sys_rst;

    // Lock loss puts the design back in reset at once
    a_lock_loss: assert property (@(posedge sys_clk_i) !pll_lock_i |=> sys_rst_o);

endmodule

//--- rtl/dp_rst_if.sv
// Reset control interface between the PIO block, the lane mappers and the top
`timescale 1ns/100ps

interface dp_rst_if;

    logic dptx_rst;
    logic dprx_rst;
    logic phy_all_rst;          // Both directions
    logic phy_tx_rst;
    logic phy_rx_rst;

    // Register side
    modport ctl (output dptx_rst, dprx_rst, phy_all_rst, phy_tx_rst, phy_rx_rst);

    // Lane mappers
    modport phy (input phy_all_rst, phy_tx_rst, phy_rx_rst);

    // Core resets brought out at the top
    modport core (input dptx_rst, dprx_rst);

endinterface

//--- rtl/dp_rx_lane_map.sv
// Receive lane mapper unpacking PHY channel words into DPRX symbols with the lane swap
`timescale 1ns/100ps

module dp_rx_lane_map
    import dp_link_pkg::*;
(
    input  logic     sys_clk_i,
    input  logic     rst_i,
    dp_rst_if.phy    rst_if,
    input  phy_bus_t phy_rx_dat_i,
    input  logic     phy_rx_vld_i,
    output rx_lnk_t  lnk_rx_dat_o,
    output logic     lnk_rx_vld_o
);

    logic    eff_rst;
    rx_lnk_t rx_unpack;
    rx_lnk_t rx_dat;
    logic    rx_vld;

    assign eff_rst = rst_i | rst_if.phy_rx_rst | rst_if.phy_all_rst;

    // Only the symbol slots are taken, disparity and pad fields dropped
    always_comb
    begin
        for (int lane = 0; lane < P_LANES; lane++)
        begin
            for (int s = 0; s < P_SPL; s++)
                rx_unpack[lane*P_SPL + s] =
                    phy_rx_dat_i[RX_CH_OF_LANE[lane]][s*P_SYM_PITCH +: P_SYM_W];
        end
    end

    always_ff @(posedge sys_clk_i)
    begin
        if (eff_rst)
        begin
            rx_vld <= 1'b0;
            rx_dat <= '0;
        end
        else
        begin
            rx_vld <= phy_rx_vld_i;
            if (phy_rx_vld_i)
                rx_dat <= rx_unpack;
        end
    end

    assign lnk_rx_dat_o = rx_dat;
    assign lnk_rx_vld_o = rx_vld;

    a_rx_hold: assert property (@(posedge sys_clk_i) eff_rst |=> !lnk_rx_vld_o);

endmodule

//--- rtl/dp_sys_pkg.sv
// System constants: PIO widths, PIO bit positions, PIO reset value, reset stretch width
package dp_sys_pkg;

    // PIO widths
    localparam int PIO_OUT_W = 8;
    localparam int PIO_IN_W  = 6;

    // PIO output bits
    localparam int PIO_CLK_SEL     = 0;     // Clock select
    localparam int PIO_DPTX_RST    = 1;
    localparam int PIO_DPRX_RST    = 2;
    localparam int PIO_PHY_ALL_RST = 3;     // Whole PHY
    localparam int PIO_PHY_TX_RST  = 4;
    localparam int PIO_PHY_RX_RST  = 5;

    // PIO input bits, 3 to 5 read zero
    localparam int PIO_PHY_CLK_LOCK = 0;
    localparam int PIO_VID_CLK_LOCK = 1;
    localparam int PIO_PHY_RDY      = 2;    // All channels ready

    // Cores and PHY held in reset, clock select low
    localparam logic [PIO_OUT_W-1:0] PIO_RST_VAL = 8'b0011_1110;

    // Reset stretch after lock
    localparam int RST_CNT_W = 10;
    localparam logic [RST_CNT_W-1:0] RST_CNT_MAX = '1;

endpackage

//--- rtl/dp_tx_lane_map.sv
// Transmit lane mapper packing DPTX symbols into PHY channel words with the lane swap
`timescale 1ns/100ps

module dp_tx_lane_map
    import dp_link_pkg::*;
(
    input  logic     sys_clk_i,
    input  logic     rst_i,
    dp_rst_if.phy    rst_if,
    input  tx_lnk_t  lnk_tx_dat_i,
    input  logic     lnk_tx_vld_i,
    output phy_bus_t phy_tx_dat_o,
    output logic     phy_tx_vld_o
);

    logic     eff_rst;
    phy_bus_t tx_pack;
    phy_bus_t tx_dat;
    logic     tx_vld;

    assign eff_rst = rst_i | rst_if.phy_tx_rst | rst_if.phy_all_rst;

    // Pad bits and the upper 32 bits stay zero
    always_comb
    begin
        tx_pack = '0;
        for (int lane = 0; lane < P_LANES; lane++)
        begin
            for (int s = 0; s < P_SPL; s++)
            begin
                tx_pack[TX_CH_OF_LANE[lane]][s*P_SYM_PITCH +: P_SYM_W] =
                    {lnk_tx_dat_i[lane*P_SPL + s].k, lnk_tx_dat_i[lane*P_SPL + s].dat};
                tx_pack[TX_CH_OF_LANE[lane]][P_DISP_VAL_LSB + s] =
                    lnk_tx_dat_i[lane*P_SPL + s].disp_val;
                tx_pack[TX_CH_OF_LANE[lane]][P_DISP_CTL_LSB + s] =
                    lnk_tx_dat_i[lane*P_SPL + s].disp_ctl;
            end
        end
    end

    // Output stage
    always_ff @(posedge sys_clk_i)
    begin
        if (eff_rst)
        begin
            tx_vld <= 1'b0;
            tx_dat <= '0;
        end
        else
        begin
            tx_vld <= lnk_tx_vld_i;
            if (lnk_tx_vld_i)
                tx_dat <= tx_pack;                  // Holds between words
        end
    end

    assign phy_tx_dat_o = tx_dat;
    assign phy_tx_vld_o = tx_vld;

    // A PIO reset bit must silence the PHY side
    a_tx_hold: assert property (@(posedge sys_clk_i) eff_rst |=> !phy_tx_vld_o);

endmodule

//--- vlog.f
+incdir+bench
rtl/dp_sys_pkg.sv
rtl/dp_link_pkg.sv
rtl/dp_rst_if.sv
rtl/dp_rst_gen.sv
rtl/dp_pio_regs.sv
rtl/dp_tx_lane_map.sv
rtl/dp_rx_lane_map.sv
rtl/dp_heartbeat.sv
rtl/dp_phy_adapter_top.sv
bench/tb_dp_phy_adapter.sv
